/* rtl/decode_consts.svh */
// data width, register count and base opcode macros
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN 64 // rv64 data width
`define NREG 32 // architectural registers

`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OPIMM    7'b0010011
`define OPC_OPIMM32  7'b0011011 // w-form immediates
`define OPC_OP       7'b0110011
`define OPC_OP32     7'b0111011 // w-form register ops
`define OPC_SYSTEM   7'b1110011

`endif

/* rtl/decode_pkg.sv */
// instruction format union, decode enums and ID/EX bundle structs
`include "decode_consts.svh"

package decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        cls_alu, cls_load, cls_store, cls_branch,
        cls_jump, cls_upper, cls_system, cls_illegal
    } op_class_e;

    typedef enum logic [1:0] {a_rs1, a_pc, a_zero} src_a_e;

    typedef enum logic [1:0] {b_rs2, b_imm, b_shamt_rs2, b_shamt_inst} src_b_e;

    typedef enum logic [2:0] {kind_i, kind_s, kind_b, kind_u, kind_j} imm_kind_e;

    typedef struct packed {
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        imm_kind_e imm_kind;
        logic      rd_wen;
        logic      word_op;
        op_class_e op_class;
        logic      is_ebreak;
        logic      is_ecall;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] imm_b;
        logic [`XLEN-1:0] imm_u;
        logic [`XLEN-1:0] imm_j;
        logic [5:0]       shamt;
    } imm_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        inst_u            inst;
        logic [`XLEN-1:0] op_a;
        logic [`XLEN-1:0] op_b;
        alu_op_e          alu_op;
        logic [4:0]       rd;
        logic             rd_wen;
        logic             word_op;
        op_class_e        op_class;
        logic             is_ebreak;
        logic             is_ecall;
    } id_ex_t;

endpackage

/* rtl/gpr_file.sv */
// gpr_file: 32x64 register file, two combinational reads, one write
`timescale 1ns/1ns
`include "decode_consts.svh"

module gpr_file (
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic [4:0]       raddr_a,
    input  logic [4:0]       raddr_b,
    output logic [`XLEN-1:0] rdata_a,
    output logic [`XLEN-1:0] rdata_b
);

    logic [`XLEN-1:0] regs [`NREG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `NREG; k++) begin
                regs[k] <= '0;
            end
        end else if (we && waddr != 5'd0) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

/* rtl/inst_classifier.sv */
// inst_classifier: opcode/funct decode into the control struct
`timescale 1ns/1ns
`include "decode_consts.svh"

module inst_classifier (
    input  decode_pkg::inst_u inst,
    output decode_pkg::ctrl_t ctrl
);

    import decode_pkg::*;

    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [5:0] shamt_hi;
    logic       f7_zero;
    logic       f7_alt;
    logic       alt_ok;
    logic       op_ok;
    logic       op32_ok;
    logic       opimm_ok;
    logic       opimm32_ok;
    logic       sys_base;

    assign opc      = inst.r.opcode;
    assign f3       = inst.r.funct3;
    assign f7       = inst.r.funct7;
    assign shamt_hi = inst.i.imm[11:6]; // rv64 shifts use 6-bit shamt
    assign f7_zero  = (f7 == 7'b0000000);
    assign f7_alt   = (f7 == 7'b0100000);
    assign alt_ok   = (f3 == 3'b000) || (f3 == 3'b101); // sub/sra slots

    assign op_ok      = f7_zero || (f7_alt && alt_ok);
    assign op32_ok    = (alt_ok || f3 == 3'b001) && op_ok;
    assign opimm32_ok = (f3 == 3'b000) || (f3 == 3'b001 && f7_zero) ||
                        (f3 == 3'b101 && (f7_zero || f7_alt));
    assign sys_base   = (inst.i.rs1 == 5'd0) && (f3 == 3'b000) && (inst.i.rd == 5'd0);

    always_comb begin
        case (f3)
            3'b001:  opimm_ok = (shamt_hi == 6'b000000);
            3'b101:  opimm_ok = (shamt_hi == 6'b000000) || (shamt_hi == 6'b010000);
            default: opimm_ok = 1'b1;
        endcase
    end

    function automatic alu_op_e alu_from_f3(input logic [2:0] fn, input logic alt);
        alu_op_e op;
        case (fn)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = alu_add;
        ctrl.src_a    = a_zero; // illegal default
        ctrl.src_b    = b_imm;
        ctrl.imm_kind = kind_i;
        ctrl.op_class = cls_illegal;
        case (opc)
            `OPC_LUI: begin
                ctrl.imm_kind = kind_u;
                ctrl.op_class = cls_upper;
            end
            `OPC_AUIPC: begin
                ctrl.src_a    = a_pc;
                ctrl.imm_kind = kind_u;
                ctrl.op_class = cls_upper;
            end
            `OPC_JAL: begin
                ctrl.src_a    = a_pc;
                ctrl.imm_kind = kind_j;
                ctrl.op_class = cls_jump;
            end
            `OPC_JALR: if (f3 == 3'b000) begin
                ctrl.src_a    = a_rs1;
                ctrl.op_class = cls_jump;
            end
            `OPC_BRANCH: if (f3 != 3'b010 && f3 != 3'b011) begin
                ctrl.src_a    = a_rs1;
                ctrl.src_b    = b_rs2;
                ctrl.imm_kind = kind_b;
                ctrl.alu_op   = alu_sub; // compare
                ctrl.op_class = cls_branch;
            end
            `OPC_LOAD: if (f3 != 3'b111) begin
                ctrl.src_a    = a_rs1;
                ctrl.op_class = cls_load;
            end
            `OPC_STORE: if (!f3[2]) begin
                ctrl.src_a    = a_rs1;
                ctrl.imm_kind = kind_s;
                ctrl.op_class = cls_store;
            end
            `OPC_OPIMM, `OPC_OPIMM32: begin
                if ((opc == `OPC_OPIMM) ? opimm_ok : opimm32_ok) begin
                    ctrl.src_a    = a_rs1;
                    ctrl.alu_op   = alu_from_f3(f3, f3 == 3'b101 && f7[5]);
                    ctrl.word_op  = (opc == `OPC_OPIMM32);
                    ctrl.op_class = cls_alu;
                    if (f3[1:0] == 2'b01) begin
                        ctrl.src_b = b_shamt_inst;
                    end
                end
            end
            `OPC_OP, `OPC_OP32: begin
                if ((opc == `OPC_OP) ? op_ok : op32_ok) begin
                    ctrl.src_a    = a_rs1;
                    ctrl.src_b    = (f3[1:0] == 2'b01) ? b_shamt_rs2 : b_rs2;
                    ctrl.alu_op   = alu_from_f3(f3, f7[5]);
                    ctrl.word_op  = (opc == `OPC_OP32);
                    ctrl.op_class = cls_alu;
                end
            end
            `OPC_SYSTEM: if (sys_base && inst.i.imm[11:1] == 11'd0) begin
                ctrl.op_class  = cls_system;
                ctrl.is_ebreak = inst.i.imm[0];
                ctrl.is_ecall  = !inst.i.imm[0];
            end
            default: ;
        endcase
        ctrl.rd_wen = ctrl.op_class inside {cls_alu, cls_load, cls_jump, cls_upper};
    end

endmodule

/* rtl/imm_gen.sv */
// imm_gen: sign-extended I/S/B/U/J immediates and shift amount
`timescale 1ns/1ns
`include "decode_consts.svh"

module imm_gen (
    input  decode_pkg::inst_u inst,
    output decode_pkg::imm_t  imm
);

    import decode_pkg::*;

    always_comb begin
        imm.imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        imm.imm_s = {{(`XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        // b and j drop bit 0
        imm.imm_b = {{(`XLEN-13){inst.b.imm_12}},
                     inst.b.imm_12,
                     inst.b.imm_11,
                     inst.b.imm_10_5,
                     inst.b.imm_4_1,
                     1'b0};
        imm.imm_u = {{(`XLEN-32){inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'b0};
        imm.imm_j = {{(`XLEN-21){inst.j.imm_20}},
                     inst.j.imm_20,
                     inst.j.imm_19_12,
                     inst.j.imm_11,
                     inst.j.imm_10_1,
                     1'b0};
        imm.shamt = inst.i.imm[5:0]; // low bits of the I field
    end

endmodule

/* rtl/operand_mux.sv */
// ALU operand selection and the ID/EX register
`timescale 1ns/1ns
`include "decode_consts.svh"

module operand_mux (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_in,
    input  logic [`XLEN-1:0]   pc_in,
    input  decode_pkg::inst_u  inst_in,
    input  decode_pkg::ctrl_t  ctrl,
    input  decode_pkg::imm_t   imm,
    input  logic [`XLEN-1:0]   rs1_val,
    input  logic [`XLEN-1:0]   rs2_val,
    output decode_pkg::id_ex_t out
);

    import decode_pkg::*;

    logic [`XLEN-1:0] imm_sel;
    logic [5:0]       shamt_src;
    logic [5:0]       shamt_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    id_ex_t           nxt;

    always_comb begin
        case (ctrl.imm_kind)
            kind_s:  imm_sel = imm.imm_s;
            kind_b:  imm_sel = imm.imm_b;
            kind_u:  imm_sel = imm.imm_u;
            kind_j:  imm_sel = imm.imm_j;
            default: imm_sel = imm.imm_i;
        endcase
    end

    assign shamt_src = (ctrl.src_b == b_shamt_rs2) ? rs2_val[5:0] : imm.shamt;
    assign shamt_val = ctrl.word_op ? {1'b0, shamt_src[4:0]} : shamt_src; // w ops shift by 5

    always_comb begin
        case (ctrl.src_a)
            a_rs1:   op_a = rs1_val;
            a_pc:    op_a = pc_in;
            default: op_a = '0; // a_zero, illegal too
        endcase
        case (ctrl.src_b)
            b_rs2:   op_b = rs2_val;
            b_imm:   op_b = imm_sel;
            default: op_b = {{(`XLEN-6){1'b0}}, shamt_val};
        endcase
    end

    always_comb begin
        nxt           = '0;
        nxt.valid     = 1'b1;
        nxt.pc        = pc_in;
        nxt.inst      = inst_in;
        nxt.op_a      = op_a;
        nxt.op_b      = op_b;
        nxt.alu_op    = ctrl.alu_op;
        nxt.rd        = inst_in.r.rd;
        nxt.rd_wen    = ctrl.rd_wen;
        nxt.word_op   = ctrl.word_op;
        nxt.op_class  = ctrl.op_class;
        nxt.is_ebreak = ctrl.is_ebreak;
        nxt.is_ecall  = ctrl.is_ecall;
    end

    always_ff @(posedge clk) begin
        if (rst || !valid_in) begin
            out <= '0; // bubble
        end else begin
            out <= nxt;
        end
    end

endmodule

/* rtl/decode_stage.sv */
// decode_stage: top level of the decode stage
`timescale 1ns/1ns
`include "decode_consts.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_in,
    input  logic [`XLEN-1:0]   pc_in,
    input  decode_pkg::inst_u  inst_in,
    input  logic               gpr_we,
    input  logic [4:0]         gpr_waddr,
    input  logic [`XLEN-1:0]   gpr_wdata,
    output decode_pkg::id_ex_t out
);

    import decode_pkg::*;

    ctrl_t            ctrl;
    imm_t             imm;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;

    gpr_file u_gpr_file (
        .clk     (clk),
        .rst     (rst),
        .we      (gpr_we),
        .waddr   (gpr_waddr),
        .wdata   (gpr_wdata),
        .raddr_a (inst_in.r.rs1),
        .raddr_b (inst_in.r.rs2),
        .rdata_a (rs1_val),
        .rdata_b (rs2_val)
    );

    inst_classifier u_inst_classifier (
        .inst (inst_in),
        .ctrl (ctrl)
    );

    imm_gen u_imm_gen (
        .inst (inst_in),
        .imm  (imm)
    );

    operand_mux u_operand_mux (
        .clk      (clk),
        .rst      (rst),
        .valid_in (valid_in),
        .pc_in    (pc_in),
        .inst_in  (inst_in),
        .ctrl     (ctrl),
        .imm      (imm),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .out      (out)
    );

endmodule

/* sim/decode_ref.svh */
// reference function for the expected ID/EX bundle of one instruction, with its helpers
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic alu_op_e funct3_alu(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? alu_sub : alu_add;
        3'd1:    return alu_sll;
        3'd2:    return alu_slt;
        3'd3:    return alu_sltu;
        3'd4:    return alu_xor;
        3'd5:    return alt ? alu_sra : alu_srl;
        3'd6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

function automatic logic [63:0] masked_shamt(input logic [5:0] sh, input logic word);
    return word ? {59'd0, sh[4:0]} : {58'd0, sh}; // word shifts use 5 bits
endfunction

function automatic id_ex_t expected_bundle(input logic [31:0] w, input logic [63:0] pc,
                                          input logic [63:0] rs1v, input logic [63:0] rs2v);
    id_ex_t      e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        shift;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    opc   = w[6:0];
    f3    = w[14:12];
    shift = (f3 == 3'b001) || (f3 == 3'b101);
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_u = {{32{w[31]}}, w[31:12], 12'b0};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    e          = '0;
    e.valid    = 1'b1;
    e.pc       = pc;
    e.inst     = w;
    e.rd       = w[11:7];
    e.alu_op   = alu_add;
    e.op_class = cls_illegal;
    e.op_b     = imm_i; // illegal keeps the I immediate
    case (opc)
        `OPC_LUI: begin
            e.op_b     = imm_u;
            e.op_class = cls_upper;
        end
        `OPC_AUIPC: begin
            e.op_a     = pc;
            e.op_b     = imm_u;
            e.op_class = cls_upper;
        end
        `OPC_JAL: begin
            e.op_a     = pc;
            e.op_b     = imm_j;
            e.op_class = cls_jump;
        end
        `OPC_JALR: begin
            e.op_a     = rs1v;
            e.op_class = cls_jump;
        end
        `OPC_BRANCH: begin
            e.op_a     = rs1v;
            e.op_b     = rs2v;
            e.alu_op   = alu_sub;
            e.op_class = cls_branch;
        end
        `OPC_LOAD: begin
            e.op_a     = rs1v;
            e.op_class = cls_load;
        end
        `OPC_STORE: begin
            e.op_a     = rs1v;
            e.op_b     = imm_s;
            e.op_class = cls_store;
        end
        `OPC_OPIMM, `OPC_OPIMM32: begin
            e.word_op  = (opc == `OPC_OPIMM32);
            e.op_a     = rs1v;
            e.op_b     = shift ? masked_shamt(w[25:20], e.word_op) : imm_i;
            e.alu_op   = funct3_alu(f3, (f3 == 3'b101) && w[30]);
            e.op_class = cls_alu;
        end
        `OPC_OP, `OPC_OP32: begin
            e.word_op  = (opc == `OPC_OP32);
            e.op_a     = rs1v;
            e.op_b     = shift ? masked_shamt(rs2v[5:0], e.word_op) : rs2v;
            e.alu_op   = funct3_alu(f3, w[30]);
            e.op_class = cls_alu;
        end
        `OPC_SYSTEM: if (w[31:21] == 11'd0 && w[19:7] == 13'd0) begin
            e.op_class  = cls_system;
            e.is_ebreak = w[20];
            e.is_ecall  = !w[20];
        end
        default: ;
    endcase
    e.rd_wen = (e.op_class == cls_alu) || (e.op_class == cls_load) ||
               (e.op_class == cls_jump) || (e.op_class == cls_upper);
    return e;
endfunction

`endif

/* sim/tb_decode_stage.sv */
// testbench for decode_stage: clock, reset, stimulus, compare process, check task, watchdog
`timescale 1ns/1ns
`include "decode_consts.svh"

module tb_decode_stage;

    import decode_pkg::*;

    `include "decode_ref.svh"

    localparam int PERIOD     = 40;
    localparam int N_EACH     = 60; // instructions per group
    localparam int N_GROUPS   = 5;
    localparam int SETUP      = 4 + `NREG + 2 * N_GROUPS + 8; // reset, loads, bubbles, drain
    localparam int TIMEOUT_NS = (N_EACH * N_GROUPS + SETUP) * PERIOD + 20 * PERIOD;

    logic             clk;
    logic             rst;
    logic             valid_in;
    logic [`XLEN-1:0] pc_in;
    inst_u            inst_in;
    logic             gpr_we;
    logic [4:0]       gpr_waddr;
    logic [`XLEN-1:0] gpr_wdata;
    id_ex_t           out;

    logic [`XLEN-1:0] model [`NREG]; // register contents as the DUT holds them
    id_ex_t           exp_slot;
    logic             armed  = 1'b0;
    integer           seed   = 64;
    int               errors = 0;
    int               checks = 0;

    decode_stage u_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .pc_in     (pc_in),
        .inst_in   (inst_in),
        .gpr_we    (gpr_we),
        .gpr_waddr (gpr_waddr),
        .gpr_wdata (gpr_wdata),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // random legal encoding for one test group, illegal ones in group 5
    function automatic logic [31:0] gen_inst(input int grp);
        logic [31:0] w;
        logic [2:0]  r;
        logic [2:0]  ns;
        logic [2:0]  f3;
        logic        alt;
        int          sel;
        w   = $random(seed);
        sel = $unsigned($random(seed)) % 60;
        r   = 3'($unsigned($random(seed)) % 6);
        ns  = (r == 3'd0) ? 3'd0 : (r < 3'd4) ? r + 3'd1 : r + 3'd2; // skips 1 and 5
        alt = w[30];
        f3  = w[29] ? 3'b101 : 3'b001;
        case (grp)
            1: case (sel % 5)
                0: begin
                    w[6:0]   = `OPC_LOAD;
                    w[14:12] = 3'($unsigned($random(seed)) % 7);
                end
                1: begin
                    w[6:0] = `OPC_STORE;
                    w[14]  = 1'b0;
                end
                2: begin
                    w[6:0]   = `OPC_BRANCH;
                    w[14:12] = (r < 3'd2) ? r : r + 3'd2;
                end
                3: w[6:0] = `OPC_LUI;
                default: w[6:0] = `OPC_JAL;
            endcase
            2: begin
                case (sel % 4)
                    0: w[6:0] = `OPC_OP;
                    1: w[6:0] = `OPC_OP32;
                    2: w[6:0] = `OPC_OPIMM;
                    default: w[6:0] = `OPC_OPIMM32;
                endcase
                w[14:12] = (sel % 2 == 1) ? 3'd0 : ns; // w forms only add
                if (sel % 4 < 2) begin
                    w[31:25] = (w[14:12] == 3'd0 && alt) ? 7'h20 : 7'h00;
                end
            end
            3: begin
                w[14:12] = f3;
                w[31:26] = {1'b0, (f3 == 3'b101) && alt, 4'b0000};
                case (sel % 4)
                    0: w[6:0] = `OPC_OP;
                    1: w[6:0] = `OPC_OP32;
                    2: w[6:0] = `OPC_OPIMM;
                    default: w[6:0] = `OPC_OPIMM32;
                endcase
                if (sel % 4 != 2) w[25] = 1'b0; // only slli/srli/srai take shamt[5]
            end
            4: case (sel % 4)
                0: w[6:0] = `OPC_AUIPC;
                1: w[6:0] = `OPC_JAL;
                2: w[6:0] = `OPC_LUI;
                default: begin
                    w[6:0]   = `OPC_JALR;
                    w[14:12] = 3'd0;
                end
            endcase
            default: case (sel % 3)
                0: w = 32'h0010_0073; // ebreak
                1: w = 32'h0000_0073; // ecall
                default: begin
                    while (w[6:0] inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
                                          `OPC_BRANCH, `OPC_LOAD, `OPC_STORE, `OPC_OPIMM,
                                          `OPC_OPIMM32, `OPC_OP, `OPC_OP32, `OPC_SYSTEM}) begin
                        w[6:0] = 7'($random(seed));
                    end
                end
            endcase
        endcase
        return w;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
        @(posedge clk);
        gpr_we    <= 1'b1;
        gpr_waddr <= addr;
        gpr_wdata <= data;
    endtask

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        valid_in <= 1'b1;
        inst_in  <= w;
        pc_in    <= rand64() & ~64'd3;
    endtask

    task automatic bubble();
        @(posedge clk);
        valid_in <= 1'b0;
        gpr_we   <= 1'b0;
    endtask

    // out at this edge belongs to the inputs sampled one edge earlier
    always @(posedge clk) begin
        if (armed) begin
            compare_value("valid", out.valid, exp_slot.valid);
            compare_value("pc", out.pc, exp_slot.pc);
            compare_value("inst", out.inst, exp_slot.inst);
            compare_value("op_a", out.op_a, exp_slot.op_a);
            compare_value("op_b", out.op_b, exp_slot.op_b);
            compare_value("alu_op", out.alu_op, exp_slot.alu_op);
            compare_value("rd", out.rd, exp_slot.rd);
            compare_value("rd_wen", out.rd_wen, exp_slot.rd_wen);
            compare_value("word_op", out.word_op, exp_slot.word_op);
            compare_value("op_class", out.op_class, exp_slot.op_class);
            compare_value("is_ebreak", out.is_ebreak, exp_slot.is_ebreak);
            compare_value("is_ecall", out.is_ecall, exp_slot.is_ecall);
        end
        if (rst) begin
            armed    = 1'b1;
            exp_slot = '0;
            foreach (model[k]) model[k] = '0;
        end else begin
            if (valid_in) begin
                exp_slot = expected_bundle(inst_in, pc_in,
                                           model[inst_in.r.rs1], model[inst_in.r.rs2]);
            end else begin
                exp_slot = '0;
            end
            if (gpr_we && gpr_waddr != 5'd0) model[gpr_waddr] = gpr_wdata; // after the read
        end
    end

    initial begin
        rst       = 1'b1;
        valid_in  = 1'b0;
        pc_in     = '0;
        inst_in   = '0;
        gpr_we    = 1'b0;
        gpr_waddr = '0;
        gpr_wdata = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < `NREG; k++) begin
            write_reg(5'(k), rand64()); // x0 write must be dropped
        end
        bubble();
        for (int g = 1; g <= N_GROUPS; g++) begin
            for (int n = 0; n < N_EACH; n++) begin
                issue(gen_inst(g));
                if (g == 2) begin
                    gpr_we    <= 1'b1; // write in the same cycle as the reads
                    gpr_waddr <= 5'($random(seed));
                    gpr_wdata <= rand64();
                end
            end
            bubble();
        end
        repeat (3) bubble();
        @(negedge clk);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0 && checks > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* decode_stage.f */
+incdir+rtl
+incdir+sim
rtl/decode_pkg.sv
rtl/gpr_file.sv
rtl/inst_classifier.sv
rtl/imm_gen.sv
rtl/operand_mux.sv
rtl/decode_stage.sv
sim/tb_decode_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_decode_stage \
    -f decode_stage.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_decode_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    exit 0
fi
exit 1
